// File: design/fibPkg.sv
package fibPkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////

    localparam int DATA_W   = 16;
    localparam int NUM_REGS = 16;
    localparam int ADDR_W   = $clog2(NUM_REGS);

    // register and bus value, wraps mod 2^16
    typedef logic [DATA_W-1:0] dataWord_t;
    // register select
    typedef logic [ADDR_W-1:0] regAddr_t;
    // alu opcode
    typedef logic [7:0] aluOp_t;
    // one enable per bus driver
    typedef logic [3:0] busCtrl_t;

    ////////////////////////////////////////
    // opcodes and bus words
    ////////////////////////////////////////

    // pass operand b
    localparam aluOp_t OP_NOP = 8'h00;
    // a + b, carry out to overflow
    localparam aluOp_t OP_ADD = 8'h01;

    // immediate driver only
    localparam busCtrl_t BUS_IMM = 4'b0001;
    // the three alu result drivers
    localparam busCtrl_t BUS_ALU = 4'b1110;

    // the two registers the sequence lives in
    localparam regAddr_t REG_R0 = 4'd0;
    localparam regAddr_t REG_R1 = 4'd1;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_R0,
        ST_LOAD_R1,
        ST_ADD_R1,
        ST_ADD_R0
    } seqState_t;

endpackage

// File: design/fibSequencer.sv
`timescale 1ns/1ns

module fibSequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output fibPkg::dataWord_t initialR,
    output fibPkg::regAddr_t  regWrite,
    output fibPkg::regAddr_t  regRead1,
    output fibPkg::regAddr_t  regRead2,
    output fibPkg::aluOp_t    ALUOp,
    output fibPkg::busCtrl_t  buffCtrl,
    output logic              regWriteEn
);
    import fibPkg::*;

    seqState_t state;
    seqState_t nextState;

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    // idle -> two loads -> add loop, no exit but reset
    always_comb begin
        nextState = state;
        case (state)
            ST_IDLE: begin
                // start only looked at here
                if (start) begin
                    nextState = ST_LOAD_R0;
                end
            end
            ST_LOAD_R0: nextState = ST_LOAD_R1;
            ST_LOAD_R1: nextState = ST_ADD_R1;
            ST_ADD_R1:  nextState = ST_ADD_R0;
            ST_ADD_R0:  nextState = ST_ADD_R1;
            default:    nextState = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // micro-op decode
    ////////////////////////////////////////

    // straight from state, no output register
    always_comb begin
        // inactive unless a state says otherwise
        initialR   = '0;
        regWrite   = REG_R0;
        regRead1   = REG_R0;
        regRead2   = REG_R0;
        ALUOp      = OP_NOP;
        buffCtrl   = '0;
        regWriteEn = 1'b0;
        case (state)
            ST_LOAD_R0: begin
                // mov R0, 1
                initialR   = 16'd1;
                regWrite   = REG_R0;
                buffCtrl   = BUS_IMM;
                regWriteEn = 1'b1;
            end
            ST_LOAD_R1: begin
                // mov R1, 1
                initialR   = 16'd1;
                regWrite   = REG_R1;
                buffCtrl   = BUS_IMM;
                regWriteEn = 1'b1;
            end
            ST_ADD_R1: begin
                // add R1, R0
                regWrite   = REG_R1;
                regRead1   = REG_R0;
                regRead2   = REG_R1;
                ALUOp      = OP_ADD;
                buffCtrl   = BUS_ALU;
                regWriteEn = 1'b1;
            end
            ST_ADD_R0: begin
                // add R0, R1
                regWrite   = REG_R0;
                regRead1   = REG_R1;
                regRead2   = REG_R0;
                ALUOp      = OP_ADD;
                buffCtrl   = BUS_ALU;
                regWriteEn = 1'b1;
            end
            default: begin
                // idle, defaults hold
                regWriteEn = 1'b0;
            end
        endcase
    end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic              clk,
    input  logic              reset,
    input  fibPkg::regAddr_t  regWrite,
    input  fibPkg::regAddr_t  regRead1,
    input  fibPkg::regAddr_t  regRead2,
    input  logic              regWriteEn,
    input  fibPkg::busCtrl_t  buffCtrl,
    input  fibPkg::dataWord_t initialR,
    input  fibPkg::dataWord_t aluResult,
    output fibPkg::dataWord_t readData1,
    output fibPkg::dataWord_t readData2,
    output fibPkg::dataWord_t fibValue,
    output logic              fibValid
);
    import fibPkg::*;

    dataWord_t regs [NUM_REGS];
    dataWord_t immDrive;
    dataWord_t aluDrive;
    dataWord_t writeBus;

    ////////////////////////////////////////
    // write bus
    ////////////////////////////////////////

    // immediate buffer on bit 0
    assign immDrive = buffCtrl[0] ? initialR : '0;
    // alu buffers, needs all three on
    assign aluDrive = (&buffCtrl[3:1]) ? aluResult : '0;
    // disabled buffers drive zero, so or them together
    assign writeBus = immDrive | aluDrive;

    ////////////////////////////////////////
    // storage and read ports
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWriteEn) begin
            regs[regWrite] <= writeBus;
        end
    end

    // async reads feed the alu
    assign readData1 = regs[regRead1];
    assign readData2 = regs[regRead2];

    // write report, same edge as the write
    always_ff @(posedge clk) begin
        if (!reset) begin
            fibValue <= '0;
            fibValid <= 1'b0;
        end else begin
            fibValid <= regWriteEn;
            // hold last term when nothing written
            if (regWriteEn) begin
                fibValue <= writeBus;
            end
        end
    end

endmodule

// File: design/aluUnit.sv
`timescale 1ns/1ns

module aluUnit (
    input  logic              clk,
    input  logic              reset,
    input  fibPkg::aluOp_t    ALUOp,
    input  fibPkg::dataWord_t readData1,
    input  fibPkg::dataWord_t readData2,
    output fibPkg::dataWord_t aluResult,
    output logic              fibOverflow
);
    import fibPkg::*;

    // one extra bit for the carry
    logic [DATA_W:0] sum;

    assign sum = {1'b0, readData1} + {1'b0, readData2};

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////

    always_comb begin
        case (ALUOp)
            OP_ADD:  aluResult = sum[DATA_W-1:0];
            // nop passes b, used by the immediate loads
            OP_NOP:  aluResult = readData2;
            default: aluResult = '0;
        endcase
    end

    ////////////////////////////////////////
    // sticky overflow
    ////////////////////////////////////////

    // set on first carry out of an add, only reset clears
    always_ff @(posedge clk) begin
        if (!reset) begin
            fibOverflow <= 1'b0;
        end else if ((ALUOp == OP_ADD) && sum[DATA_W]) begin
            fibOverflow <= 1'b1;
        end
    end

endmodule

// File: design/fibTop.sv
`timescale 1ns/1ns

module fibTop (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output fibPkg::dataWord_t fibValue,
    output logic              fibValid,
    output logic              fibOverflow
);
    import fibPkg::*;

    // sequencer to register file
    dataWord_t initialR;
    regAddr_t  regWrite;
    regAddr_t  regRead1;
    regAddr_t  regRead2;
    busCtrl_t  buffCtrl;
    logic      regWriteEn;
    // sequencer to alu
    aluOp_t    ALUOp;
    // register file <-> alu loop
    dataWord_t readData1;
    dataWord_t readData2;
    dataWord_t aluResult;

    fibSequencer i_fibSequencer (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .initialR   (initialR),
        .regWrite   (regWrite),
        .regRead1   (regRead1),
        .regRead2   (regRead2),
        .ALUOp      (ALUOp),
        .buffCtrl   (buffCtrl),
        .regWriteEn (regWriteEn)
    );

    regFile i_regFile (
        .clk        (clk),
        .reset      (reset),
        .regWrite   (regWrite),
        .regRead1   (regRead1),
        .regRead2   (regRead2),
        .regWriteEn (regWriteEn),
        .buffCtrl   (buffCtrl),
        .initialR   (initialR),
        .aluResult  (aluResult),
        .readData1  (readData1),
        .readData2  (readData2),
        .fibValue   (fibValue),
        .fibValid   (fibValid)
    );

    // result goes back to the write bus in the same cycle
    aluUnit i_aluUnit (
        .clk         (clk),
        .reset       (reset),
        .ALUOp       (ALUOp),
        .readData1   (readData1),
        .readData2   (readData2),
        .aluResult   (aluResult),
        .fibOverflow (fibOverflow)
    );

endmodule

// File: dv/fibTb.sv
`timescale 1ns/1ns

module fibTb;
    import fibPkg::*;

    logic      clk;
    logic      reset;
    logic      start;
    dataWord_t fibValue;
    logic      fibValid;
    logic      fibOverflow;

    logic [31:0] lfsrState;
    // terms seen since the last start
    int          termCount;
    // first term whose add carries out
    int          carryTerm;
    bit          runActive;
    bit          seenValid;

    fibTop i_fibTop (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .fibValue    (fibValue),
        .fibValid    (fibValid),
        .fibOverflow (fibOverflow)
    );

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // random numbers and reference model
    ////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] randBits(input int width);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < width; i++) begin
            val = {val[30:0], stepLfsr()};
        end
        return val;
    endfunction

    // nth term mod 2^16 with F1 = F2 = 1
    function automatic dataWord_t fibRef(input int n);
        dataWord_t a;
        dataWord_t b;
        dataWord_t t;
        a = 16'd1;
        b = 16'd1;
        for (int i = 3; i <= n; i++) begin
            t = a + b;
            a = b;
            b = t;
        end
        return b;
    endfunction

    // index of first term above 16 bits in unwrapped math
    function automatic int firstCarryTerm();
        int a;
        int b;
        int t;
        int idx;
        a = 1;
        b = 1;
        idx = 2;
        while (b <= 65535) begin
            t = a + b;
            a = b;
            b = t;
            idx++;
        end
        return idx;
    endfunction

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s got 0x%h expected 0x%h at term %0d",
                     name, actual, expected, termCount);
            $display("Checks failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout: %s", what);
        $display("Checks failed");
        $fatal(1, "wait timed out");
    endtask

    // compare each term once outputs have settled
    always @(negedge clk) begin
        if (runActive) begin
            // no gaps once the stream is up
            if (seenValid) begin
                checkValue("fibValid", {31'd0, fibValid}, 32'd1);
            end
            if (fibValid) begin
                seenValid = 1'b1;
                termCount = termCount + 1;
                checkValue("fibValue", {16'd0, fibValue}, {16'd0, fibRef(termCount)});
                checkValue("fibOverflow", {31'd0, fibOverflow},
                           {31'd0, (termCount >= carryTerm)});
            end
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    // outputs quiet before start
    task automatic checkIdleOutputs(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkValue("fibValid", {31'd0, fibValid}, 32'd0);
            checkValue("fibValue", {16'd0, fibValue}, 32'd0);
            checkValue("fibOverflow", {31'd0, fibOverflow}, 32'd0);
        end
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        termCount = 0;
        seenValid = 1'b0;
        runActive = 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic waitFirstValid();
        int cycles;
        cycles = 0;
        while (!seenValid) begin
            @(posedge clk);
            cycles++;
            if (cycles > 8) begin
                timeoutFail("fibValid never rose after start");
            end
        end
    endtask

    task automatic waitTerms(input int target);
        int cycles;
        cycles = 0;
        while (termCount < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > target + 16) begin
                timeoutFail("stream stalled before enough terms were seen");
            end
        end
    endtask

    // mid-run reset clears outputs on its first edge and holds them
    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b0;
        runActive = 1'b0;
        repeat (3) begin
            @(posedge clk);
            checkIdleOutputs(1);
        end
        @(posedge clk);
        reset <= 1'b1;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int idleDelay;
        int runLength;
        reset = 1'b0;
        start = 1'b0;
        lfsrState = 32'hc493f811;
        termCount = 0;
        runActive = 1'b0;
        seenValid = 1'b0;
        carryTerm = firstCarryTerm();
        repeat (3) @(posedge clk);
        reset <= 1'b1;

        // first run goes well past the wrap
        idleDelay = int'(randBits(4));
        runLength = 40 + int'(randBits(5));
        checkIdleOutputs(idleDelay);
        pulseStart();
        waitFirstValid();
        waitTerms(runLength);
        applyReset();

        // restart from F1 and see overflow rise again
        idleDelay = int'(randBits(4));
        checkIdleOutputs(idleDelay);
        pulseStart();
        waitFirstValid();
        waitTerms(carryTerm + 8);
        runActive = 1'b0;

        $display("All checks passed");
        $finish;
    end

endmodule

// File: flist.f
design/fibPkg.sv
design/fibSequencer.sv
design/regFile.sv
design/aluUnit.sv
design/fibTop.sv
dv/fibTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the fibonacci testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir="obj_dir"
logFile="sim.log"
passMsg="All checks passed"

verilator --binary --timing -sv \
    --top-module fibTb \
    -Mdir "$buildDir" \
    -o fibSim \
    -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/fibSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

# the log decides pass or fail
if grep -q "^${passMsg}\$" "$logFile"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
